// ==== build.sh ====
#!/bin/sh
# Compile and run the cpu_core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module cpu_core_tb --Mdir "$OBJ_DIR" -f cpu_core.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ_DIR/Vcpu_core_tb" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    exit 1
fi
exit 0

// ==== cpu_core.f ====
+incdir+source
source/cpu_pkg.sv
source/pipe_if.sv
source/fetch_stage.sv
source/reg_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/cpu_core.sv
test/cpu_core_assertions.sv
test/cpu_core_tb.sv

// ==== source/cpu_core.sv ====
/*
 * Five-stage core top level, stage and interface wiring
 */
`timescale 1ns/100ps
`include "cpu_macros.svh"

module cpu_core (
    input  logic                   clk,
    input  logic                   rst_n,
    output logic [`CPU_XLEN-1:0]   imem_addr,
    input  logic [`CPU_XLEN-1:0]   imem_data,
    output logic [`CPU_XLEN-1:0]   dmem_addr,
    output logic [`CPU_XLEN-1:0]   dmem_wdata,
    output logic                   dmem_we,
    input  logic [`CPU_XLEN-1:0]   dmem_rdata,
    // Writeback debug port
    output logic                   debug_wb_ena,
    output logic [`CPU_REG_AW-1:0] debug_wb_reg,
    output logic [`CPU_XLEN-1:0]   debug_wb_value,
    output logic [`CPU_XLEN-1:0]   debug_wb_pc
);

    logic                 stall;
    logic                 redirect_taken;
    logic [`CPU_XLEN-1:0] redirect_pc;
    logic [`CPU_XLEN-1:0] pc_d;
    logic [`CPU_XLEN-1:0] instr_d;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();
    wb_if     wb ();

    fetch_stage fetch_stage_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .redirect_taken (redirect_taken),
        .redirect_pc    (redirect_pc),
        .imem_addr      (imem_addr),
        .imem_data      (imem_data),
        .pc_d           (pc_d),
        .instr_d        (instr_d)
    );

    decode_stage decode_stage_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .pc_d           (pc_d),
        .instr_d        (instr_d),
        .redirect_taken (redirect_taken),
        .stall          (stall),
        .wb             (wb.sink),
        .id_ex          (id_ex.source)
    );

    execute_stage execute_stage_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .id_ex          (id_ex.sink),
        .wb             (wb.sink),
        .ex_mem         (ex_mem.source),
        .redirect_taken (redirect_taken),
        .redirect_pc    (redirect_pc)
    );

    memory_stage memory_stage_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_mem     (ex_mem.sink),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata),
        .wb         (wb.source)
    );

    // Debug port mirrors the writeback bus
    assign debug_wb_ena   = wb.reg_we;
    assign debug_wb_reg   = wb.rd;
    assign debug_wb_value = wb.data;
    assign debug_wb_pc    = wb.pc;

endmodule

// ==== source/cpu_macros.svh ====
/*
 * Core-wide width, register count, reset address and bubble encoding
 */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data and address width
`define CPU_XLEN 32

// Register index width and register count
`define CPU_REG_AW 5
`define CPU_REG_COUNT 32

// First fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

// addi x0,x0,0 used to squash an instruction slot
`define CPU_BUBBLE_WORD 32'h0000_0013

`endif

// ==== source/cpu_pkg.sv ====
/*
 * Opcode, ALU operation, writeback and forward select types,
 * plus the decoded control struct carried down the pipeline
 */
package cpu_pkg;

    // Major opcodes of the supported formats
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_t;

    // ALU_ADD is zero so an all-zero control word stays harmless
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6
    } alu_op_t;

    typedef enum logic {
        WB_ALU = 1'b0,
        WB_MEM = 1'b1
    } wb_sel_t;

    // Operand source in execute
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwd_sel_t;

    // Decoded control, all zero is a bubble
    typedef struct packed {
        logic    reg_we;
        logic    mem_we;
        logic    mem_re;
        wb_sel_t wb_sel;
        alu_op_t alu_op;
        logic    imm_src;
        logic    is_branch;
        logic    branch_ne;
        logic    is_jal;
    } ctrl_t;

endpackage

// ==== source/decode_stage.sv ====
/*
 * Instruction decode, immediate build, load-use stall and ID/EX register
 */
`timescale 1ns/100ps
`include "cpu_macros.svh"

module decode_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`CPU_XLEN-1:0] pc_d,
    input  logic [`CPU_XLEN-1:0] instr_d,
    input  logic                 redirect_taken,
    output logic                 stall,
    wb_if.sink                   wb,
    id_ex_if.source              id_ex
);

    cpu_pkg::opcode_t       opcode;
    logic [2:0]             funct3;
    logic                   funct7_b5;
    logic [`CPU_REG_AW-1:0] rs1;
    logic [`CPU_REG_AW-1:0] rs2;
    logic [`CPU_REG_AW-1:0] rd;
    logic [`CPU_XLEN-1:0]   rs1_val;
    logic [`CPU_XLEN-1:0]   rs2_val;
    logic [`CPU_XLEN-1:0]   imm;
    cpu_pkg::ctrl_t         ctrl;
    logic                   uses_rs1;
    logic                   uses_rs2;
    logic                   legal;

    assign opcode    = cpu_pkg::opcode_t'(instr_d[6:0]);
    assign funct3    = instr_d[14:12];
    assign funct7_b5 = instr_d[30];
    assign rs1       = instr_d[19:15];
    assign rs2       = instr_d[24:20];
    assign rd        = instr_d[11:7];

    reg_file reg_file_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .wb      (wb)
    );

    ////////////////////////////////////////////////////////////
    // Control and immediate decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        ctrl     = '0;
        imm      = '0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        legal    = 1'b1;
        case (opcode)
            cpu_pkg::OPC_OP: begin
                ctrl.reg_we = 1'b1;
                uses_rs1    = 1'b1;
                uses_rs2    = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = funct7_b5 ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
                    3'b111:  ctrl.alu_op = cpu_pkg::ALU_AND;
                    3'b110:  ctrl.alu_op = cpu_pkg::ALU_OR;
                    3'b100:  ctrl.alu_op = cpu_pkg::ALU_XOR;
                    3'b010:  ctrl.alu_op = cpu_pkg::ALU_SLT;
                    default: legal = 1'b0;
                endcase
            end
            cpu_pkg::OPC_OP_IMM: begin
                // ADDI only
                ctrl.reg_we  = 1'b1;
                ctrl.imm_src = 1'b1;
                uses_rs1     = 1'b1;
                imm          = {{20{instr_d[31]}}, instr_d[31:20]};
                legal        = (funct3 == 3'b000);
            end
            cpu_pkg::OPC_LUI: begin
                ctrl.reg_we  = 1'b1;
                ctrl.imm_src = 1'b1;
                ctrl.alu_op  = cpu_pkg::ALU_PASS_B;
                imm          = {instr_d[31:12], 12'b0};
            end
            cpu_pkg::OPC_LOAD: begin
                ctrl.reg_we  = 1'b1;
                ctrl.mem_re  = 1'b1;
                ctrl.wb_sel  = cpu_pkg::WB_MEM;
                ctrl.imm_src = 1'b1;
                uses_rs1     = 1'b1;
                imm          = {{20{instr_d[31]}}, instr_d[31:20]};
                legal        = (funct3 == 3'b010);
            end
            cpu_pkg::OPC_STORE: begin
                ctrl.mem_we  = 1'b1;
                ctrl.imm_src = 1'b1;
                uses_rs1     = 1'b1;
                uses_rs2     = 1'b1;
                imm          = {{20{instr_d[31]}}, instr_d[31:25], instr_d[11:7]};
                legal        = (funct3 == 3'b010);
            end
            cpu_pkg::OPC_BRANCH: begin
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = funct3[0];
                uses_rs1       = 1'b1;
                uses_rs2       = 1'b1;
                imm            = {{19{instr_d[31]}}, instr_d[31], instr_d[7],
                                  instr_d[30:25], instr_d[11:8], 1'b0};
                // BEQ and BNE only
                legal          = (funct3[2:1] == 2'b00);
            end
            cpu_pkg::OPC_JAL: begin
                ctrl.reg_we = 1'b1;
                ctrl.is_jal = 1'b1;
                imm         = {{11{instr_d[31]}}, instr_d[31], instr_d[19:12],
                               instr_d[20], instr_d[30:21], 1'b0};
            end
            default: legal = 1'b0;
        endcase

        // Unsupported words turn into bubbles
        if (!legal) begin
            ctrl     = '0;
            uses_rs1 = 1'b0;
            uses_rs2 = 1'b0;
        end
        ctrl.reg_we = ctrl.reg_we && (rd != '0);
    end

    // Load in execute feeding an operand of this instruction
    assign stall = id_ex.ctrl.mem_re && (id_ex.rd != '0) &&
                   ((uses_rs1 && (rs1 == id_ex.rd)) || (uses_rs2 && (rs2 == id_ex.rd)));

    ////////////////////////////////////////////////////////////
    // ID/EX register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n || stall || redirect_taken) begin
            id_ex.ctrl <= '0;
            id_ex.rd   <= '0;
        end else begin
            id_ex.ctrl <= ctrl;
            id_ex.rd   <= rd;
        end
    end

    always_ff @(posedge clk) begin
        id_ex.pc      <= pc_d;
        id_ex.rs1     <= rs1;
        id_ex.rs2     <= rs2;
        id_ex.rs1_val <= rs1_val;
        id_ex.rs2_val <= rs2_val;
        id_ex.imm     <= imm;
    end

endmodule

// ==== source/execute_stage.sv ====
/*
 * Operand forwarding, ALU, branch compare, redirect and EX/MEM register
 */
`timescale 1ns/100ps
`include "cpu_macros.svh"

module execute_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    id_ex_if.sink                id_ex,
    wb_if.sink                   wb,
    ex_mem_if.source             ex_mem,
    output logic                 redirect_taken,
    output logic [`CPU_XLEN-1:0] redirect_pc
);

    cpu_pkg::fwd_sel_t    fwd_a;
    cpu_pkg::fwd_sel_t    fwd_b;
    logic [`CPU_XLEN-1:0] src_a;
    logic [`CPU_XLEN-1:0] src_b;
    logic [`CPU_XLEN-1:0] op_b;
    logic [`CPU_XLEN-1:0] alu_out;
    logic [`CPU_XLEN-1:0] result;
    logic                 branch_eq;

    // Loads in EX/MEM never forward, decode stalls those cases
    function automatic cpu_pkg::fwd_sel_t fwd_sel_for(input logic [`CPU_REG_AW-1:0] src);
        if (ex_mem.ctrl.reg_we && !ex_mem.ctrl.mem_re &&
            (ex_mem.rd != '0) && (ex_mem.rd == src)) begin
            return cpu_pkg::FWD_MEM;
        end else if (wb.reg_we && (wb.rd == src)) begin
            return cpu_pkg::FWD_WB;
        end
        return cpu_pkg::FWD_REG;
    endfunction

    function automatic logic [`CPU_XLEN-1:0] fwd_value(input cpu_pkg::fwd_sel_t sel,
                                                       input logic [`CPU_XLEN-1:0] reg_val);
        case (sel)
            cpu_pkg::FWD_MEM: return ex_mem.result;
            cpu_pkg::FWD_WB:  return wb.data;
            default:          return reg_val;
        endcase
    endfunction

    assign fwd_a = fwd_sel_for(id_ex.rs1);
    assign fwd_b = fwd_sel_for(id_ex.rs2);
    assign src_a = fwd_value(fwd_a, id_ex.rs1_val);
    assign src_b = fwd_value(fwd_b, id_ex.rs2_val);
    assign op_b  = id_ex.ctrl.imm_src ? id_ex.imm : src_b;

    ////////////////////////////////////////////////////////////
    // ALU and branch
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (id_ex.ctrl.alu_op)
            cpu_pkg::ALU_SUB:    alu_out = src_a - op_b;
            cpu_pkg::ALU_AND:    alu_out = src_a & op_b;
            cpu_pkg::ALU_OR:     alu_out = src_a | op_b;
            cpu_pkg::ALU_XOR:    alu_out = src_a ^ op_b;
            cpu_pkg::ALU_SLT:    alu_out = {{(`CPU_XLEN-1){1'b0}}, $signed(src_a) < $signed(op_b)};
            cpu_pkg::ALU_PASS_B: alu_out = op_b;
            default:             alu_out = src_a + op_b;
        endcase
    end

    assign branch_eq = (src_a == src_b);

    // BNE flips the equality test
    assign redirect_taken = id_ex.ctrl.is_jal ||
                            (id_ex.ctrl.is_branch && (branch_eq ^ id_ex.ctrl.branch_ne));
    assign redirect_pc    = id_ex.pc + id_ex.imm;

    // JAL links pc+4
    assign result = id_ex.ctrl.is_jal ? id_ex.pc + `CPU_XLEN'd4 : alu_out;

    ////////////////////////////////////////////////////////////
    // EX/MEM register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem.ctrl <= '0;
        end else begin
            ex_mem.ctrl <= id_ex.ctrl;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem.result     <= result;
        ex_mem.store_data <= src_b;
        ex_mem.rd         <= id_ex.rd;
        ex_mem.pc         <= id_ex.pc;
    end

endmodule

// ==== source/fetch_stage.sv ====
/*
 * PC register and IF/ID register with stall hold and redirect squash
 */
`timescale 1ns/100ps
`include "cpu_macros.svh"

module fetch_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  logic                 redirect_taken,
    input  logic [`CPU_XLEN-1:0] redirect_pc,
    output logic [`CPU_XLEN-1:0] imem_addr,
    input  logic [`CPU_XLEN-1:0] imem_data,
    output logic [`CPU_XLEN-1:0] pc_d,
    output logic [`CPU_XLEN-1:0] instr_d
);

    logic [`CPU_XLEN-1:0] pc;

    assign imem_addr = pc;

    // Redirect wins over stall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc      <= `CPU_RESET_PC;
            instr_d <= `CPU_BUBBLE_WORD;
        end else if (redirect_taken) begin
            pc      <= redirect_pc;
            instr_d <= `CPU_BUBBLE_WORD;
        end else if (!stall) begin
            pc      <= pc + `CPU_XLEN'd4;
            instr_d <= imem_data;
        end
    end

    // PC of the word in decode
    always_ff @(posedge clk) begin
        if (!stall || redirect_taken) begin
            pc_d <= pc;
        end
    end

endmodule

// ==== source/memory_stage.sv ====
/*
 * Data memory port drive, MEM/WB register and writeback select
 */
`timescale 1ns/100ps
`include "cpu_macros.svh"

module memory_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    ex_mem_if.sink               ex_mem,
    output logic [`CPU_XLEN-1:0] dmem_addr,
    output logic [`CPU_XLEN-1:0] dmem_wdata,
    output logic                 dmem_we,
    input  logic [`CPU_XLEN-1:0] dmem_rdata,
    wb_if.source                 wb
);

    // Word access only, memory answers in the same cycle
    assign dmem_addr  = ex_mem.result;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_we    = ex_mem.ctrl.mem_we;

    ////////////////////////////////////////////////////////////
    // MEM/WB register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb.reg_we <= 1'b0;
        end else begin
            wb.reg_we <= ex_mem.ctrl.reg_we;
        end
    end

    always_ff @(posedge clk) begin
        wb.rd   <= ex_mem.rd;
        wb.pc   <= ex_mem.pc;
        wb.data <= (ex_mem.ctrl.wb_sel == cpu_pkg::WB_MEM) ? dmem_rdata : ex_mem.result;
    end

endmodule

// ==== source/pipe_if.sv ====
/*
 * Pipeline interfaces id_ex_if, ex_mem_if and wb_if with their modports
 */
`timescale 1ns/100ps
`include "cpu_macros.svh"

// Decode to execute
interface id_ex_if;
    logic [`CPU_XLEN-1:0]   pc;
    logic [`CPU_REG_AW-1:0] rs1;
    logic [`CPU_REG_AW-1:0] rs2;
    logic [`CPU_REG_AW-1:0] rd;
    logic [`CPU_XLEN-1:0]   rs1_val;
    logic [`CPU_XLEN-1:0]   rs2_val;
    logic [`CPU_XLEN-1:0]   imm;
    cpu_pkg::ctrl_t         ctrl;

    modport source (output pc, rs1, rs2, rd, rs1_val, rs2_val, imm, ctrl);
    modport sink   (input  pc, rs1, rs2, rd, rs1_val, rs2_val, imm, ctrl);
endinterface

// Execute to memory, pc travels along for the debug port
interface ex_mem_if;
    logic [`CPU_XLEN-1:0]   result;
    logic [`CPU_XLEN-1:0]   store_data;
    logic [`CPU_REG_AW-1:0] rd;
    logic [`CPU_XLEN-1:0]   pc;
    cpu_pkg::ctrl_t         ctrl;

    modport source (output result, store_data, rd, pc, ctrl);
    modport sink   (input  result, store_data, rd, pc, ctrl);
endinterface

// Writeback bus, reg_we never set for rd 0
interface wb_if;
    logic                   reg_we;
    logic [`CPU_REG_AW-1:0] rd;
    logic [`CPU_XLEN-1:0]   data;
    logic [`CPU_XLEN-1:0]   pc;

    modport source (output reg_we, rd, data, pc);
    modport sink   (input  reg_we, rd, data, pc);
endinterface

// ==== source/reg_file.sv ====
/*
 * Register file, x0 fixed at zero, write-through on same-cycle read
 */
`timescale 1ns/100ps
`include "cpu_macros.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`CPU_REG_AW-1:0] rs1,
    input  logic [`CPU_REG_AW-1:0] rs2,
    output logic [`CPU_XLEN-1:0]   rs1_val,
    output logic [`CPU_XLEN-1:0]   rs2_val,
    wb_if.sink                     wb
);

    logic [`CPU_XLEN-1:0] regs [`CPU_REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_we && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Bypass the writeback value to a read of the same register
    assign rs1_val = (rs1 == '0)                  ? '0      :
                     (wb.reg_we && wb.rd == rs1)  ? wb.data : regs[rs1];
    assign rs2_val = (rs2 == '0)                  ? '0      :
                     (wb.reg_we && wb.rd == rs2)  ? wb.data : regs[rs2];

endmodule

// ==== test/cpu_core_assertions.sv ====
/*
 * Concurrent checks on the cpu_core data and debug ports, bound to cpu_core
 */
`timescale 1ns/100ps
`include "cpu_macros.svh"

module cpu_core_assertions (
    input logic                   clk,
    input logic                   rst_n,
    input logic [`CPU_XLEN-1:0]   dmem_addr,
    input logic                   dmem_we,
    input logic                   debug_wb_ena,
    input logic [`CPU_REG_AW-1:0] debug_wb_reg
);

    // Failures seen so far, summed by the testbench
    int fail_count = 0;

    // x0 is never written back
    wb_reg_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        debug_wb_ena |-> (debug_wb_reg != '0))
    else begin
        $error("write-back reported for register x0");
        fail_count++;
    end

    // Word stores only
    store_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_we |-> (dmem_addr[1:0] == 2'b00))
    else begin
        $error("store to unaligned address %h", dmem_addr);
        fail_count++;
    end

    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> (!dmem_we && !debug_wb_ena))
    else begin
        $error("store or write-back active right after reset");
        fail_count++;
    end

    ports_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({dmem_we, debug_wb_ena}))
    else begin
        $error("store or write-back enable unknown");
        fail_count++;
    end

endmodule

bind cpu_core cpu_core_assertions cpu_core_assertions_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .dmem_addr    (dmem_addr),
    .dmem_we      (dmem_we),
    .debug_wb_ena (debug_wb_ena),
    .debug_wb_reg (debug_wb_reg)
);

// ==== test/cpu_core_tb.sv ====
/*
 * Testbench for cpu_core: clock, reset, ROM and RAM models, fixed program,
 * expected retirement and store tables, timeout and summary
 */
`timescale 1ns/100ps
`include "cpu_macros.svh"

module cpu_core_tb;

    localparam int ROM_WORDS    = 64;
    localparam int RAM_WORDS    = 16;
    // 23 instructions at three cycles each, plus margin
    localparam int CYCLE_LIMIT  = 100;
    localparam int DRAIN_CYCLES = 8;

    logic                   clk;
    logic                   rst_n;
    logic [`CPU_XLEN-1:0]   imem_addr;
    logic [`CPU_XLEN-1:0]   imem_data;
    logic [`CPU_XLEN-1:0]   dmem_addr;
    logic [`CPU_XLEN-1:0]   dmem_wdata;
    logic                   dmem_we;
    logic [`CPU_XLEN-1:0]   dmem_rdata;
    logic                   debug_wb_ena;
    logic [`CPU_REG_AW-1:0] debug_wb_reg;
    logic [`CPU_XLEN-1:0]   debug_wb_value;
    logic [`CPU_XLEN-1:0]   debug_wb_pc;

    logic [`CPU_XLEN-1:0]   rom [ROM_WORDS];
    logic [`CPU_XLEN-1:0]   ram [RAM_WORDS];
    logic [`CPU_XLEN-1:0]   exp_pc_q [$];
    logic [`CPU_REG_AW-1:0] exp_rd_q [$];
    logic [`CPU_XLEN-1:0]   exp_val_q [$];
    logic [`CPU_XLEN-1:0]   exp_addr_q [$];
    logic [`CPU_XLEN-1:0]   exp_data_q [$];

    int errors = 0;
    int assert_fails;
    int cycle_count = 0;
    int retire_seen = 0;
    int extra_retires = 0;
    int extra_stores = 0;
    bit program_done = 1'b0;

    cpu_core cpu_core_inst (.*);

    always #2 clk = ~clk;

    assign imem_data  = rom[imem_addr[7:2]];
    assign dmem_rdata = ram[dmem_addr[5:2]];

    always @(posedge clk) begin
        if (rst_n && dmem_we) begin
            ram[dmem_addr[5:2]] <= dmem_wdata;
        end
    end

    task automatic expect_retire(input logic [31:0] pc, input logic [4:0] rd,
                                 input logic [31:0] value);
        exp_pc_q.push_back(pc);
        exp_rd_q.push_back(rd);
        exp_val_q.push_back(value);
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    task automatic load_program();
        // Unused words are addi x0,x0,index and never retire
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = `CPU_BUBBLE_WORD | (`CPU_XLEN'(i) << 20);
        end
        // addi x1,x0,5  addi x2,x1,3  add x3,x1,x2  sub x4,x3,x1
        rom[0]  = 32'h0050_0093;
        rom[1]  = 32'h0030_8113;
        rom[2]  = 32'h0020_81b3;
        rom[3]  = 32'h4011_8233;
        // and x5,x4,x3  or x6,x5,x1  xor x7,x6,x2  slt x8,x7,x3  lui x9,0x12345
        rom[4]  = 32'h0032_72b3;
        rom[5]  = 32'h0012_e333;
        rom[6]  = 32'h0023_43b3;
        rom[7]  = 32'h0033_a433;
        rom[8]  = 32'h1234_54b7;
        // sw x3,8(x0)  lw x10,8(x0)  add x11,x10,x1
        rom[9]  = 32'h0030_2423;
        rom[10] = 32'h0080_2503;
        rom[11] = 32'h0015_05b3;
        // bne x1,x1,+8 falls through, beq x2,x4,+12 skips two addi x12
        rom[12] = 32'h0010_9463;
        rom[13] = 32'h0041_0663;
        rom[14] = 32'h0010_0613;
        rom[15] = 32'h0020_0613;
        // jal x13,+12 skips two addi x14
        rom[16] = 32'h00c0_06ef;
        rom[17] = 32'h0030_0713;
        rom[18] = 32'h0040_0713;
        // addi x0,x0,7  add x15,x0,x9  sw x15,12(x0)  jal x0,0
        rom[19] = 32'h0070_0013;
        rom[20] = 32'h0090_07b3;
        rom[21] = 32'h00f0_2623;
        rom[22] = 32'h0000_006f;
    endtask

    task automatic load_tables();
        expect_retire(32'h00, 5'd1, 32'd5);
        expect_retire(32'h04, 5'd2, 32'd8);
        expect_retire(32'h08, 5'd3, 32'd13);
        expect_retire(32'h0c, 5'd4, 32'd8);
        // 8 & 13, 8 | 5, 13 ^ 8, 5 < 13
        expect_retire(32'h10, 5'd5, 32'd8);
        expect_retire(32'h14, 5'd6, 32'd13);
        expect_retire(32'h18, 5'd7, 32'd5);
        expect_retire(32'h1c, 5'd8, 32'd1);
        expect_retire(32'h20, 5'd9, 32'h1234_5000);
        expect_retire(32'h28, 5'd10, 32'd13);
        expect_retire(32'h2c, 5'd11, 32'd18);
        expect_retire(32'h40, 5'd13, 32'h44);
        expect_retire(32'h50, 5'd15, 32'h1234_5000);
        expect_store(32'h08, 32'd13);
        expect_store(32'h0c, 32'h1234_5000);
    endtask

    task automatic check_retire();
        logic [`CPU_XLEN-1:0]   pc;
        logic [`CPU_REG_AW-1:0] rd;
        logic [`CPU_XLEN-1:0]   value;
        if (exp_pc_q.size() == 0) begin
            extra_retires++;
            return;
        end
        pc    = exp_pc_q.pop_front();
        rd    = exp_rd_q.pop_front();
        value = exp_val_q.pop_front();
        assert (debug_wb_pc == pc && debug_wb_reg == rd && debug_wb_value == value) else begin
            $display("CHECK FAILED at %0t: retired pc %h x%0d = %h, expected pc %h x%0d = %h",
                     $time, debug_wb_pc, debug_wb_reg, debug_wb_value, pc, rd, value);
            errors++;
        end
        // Fetch in cycle 0 retires in cycle 4
        if (retire_seen == 0) begin
            assert (cycle_count == 4) else begin
                $display("CHECK FAILED at %0t: first retirement in cycle %0d, expected 4",
                         $time, cycle_count);
                errors++;
            end
        end
        retire_seen++;
        if (exp_pc_q.size() == 0) begin
            program_done = 1'b1;
        end
    endtask

    task automatic check_store();
        logic [`CPU_XLEN-1:0] addr;
        logic [`CPU_XLEN-1:0] data;
        if (exp_addr_q.size() == 0) begin
            extra_stores++;
            return;
        end
        addr = exp_addr_q.pop_front();
        data = exp_data_q.pop_front();
        assert (dmem_addr == addr && dmem_wdata == data) else begin
            $display("CHECK FAILED at %0t: store %h to %h, expected %h to %h",
                     $time, dmem_wdata, dmem_addr, data, addr);
            errors++;
        end
    endtask

    // Outputs are settled mid-cycle
    always @(negedge clk) begin
        if (!rst_n) begin
            assert (!dmem_we && !debug_wb_ena) else begin
                $display("CHECK FAILED at %0t: store or write-back active in reset", $time);
                errors++;
            end
        end else begin
            if (cycle_count == 0) begin
                assert (imem_addr == `CPU_RESET_PC) else begin
                    $display("CHECK FAILED at %0t: first fetch from %h", $time, imem_addr);
                    errors++;
                end
            end
            if (debug_wb_ena) begin
                check_retire();
            end
            if (dmem_we) begin
                check_store();
            end
            cycle_count++;
        end
    end

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        load_program();
        load_tables();
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i] = 32'hd0d0_0000 | (32'(i) * 32'h0101_0101);
        end

        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;

        while (!program_done && cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
        end
        if (!program_done) begin
            $display("timeout: program did not finish");
            errors++;
        end else begin
            repeat (DRAIN_CYCLES) @(posedge clk);
        end

        if (exp_pc_q.size() != 0 || extra_retires != 0) begin
            $display("wrong number of retirements: %0d missing, %0d extra",
                     exp_pc_q.size(), extra_retires);
            errors++;
        end
        if (exp_addr_q.size() != 0 || extra_stores != 0) begin
            $display("wrong number of stores: %0d missing, %0d extra",
                     exp_addr_q.size(), extra_stores);
            errors++;
        end

        assert_fails = cpu_core_inst.cpu_core_assertions_inst.fail_count;
        $display("Errors: %0d check, %0d assertion", errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
